/* project.f */
+incdir+tests
rtl/pic_pkg.sv
rtl/pic_gateway_bank.sv
rtl/pic_regfile.sv
rtl/pic_priority_tree.sv
rtl/pic_claim_stage.sv
rtl/pic_ctrl.sv
tests/tb_pic_ctrl.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_pic_ctrl
FILELIST  := project.f
OBJ_DIR   := obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)

/* tests/pic_tests.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic register_readback();
  int          srcs[3] = '{1, 7, 31};
  logic [31:0] data;
  foreach (srcs[i]) begin
    bus_write(reg_addr(INTPRIORITY_BASE_ADDR, srcs[i]), 32'hdead_bee0 | 32'(srcs[i] % 16));
    read_check("register_readback", reg_addr(INTPRIORITY_BASE_ADDR, srcs[i]),
               32'(srcs[i] % 16));
    bus_write(reg_addr(INTENABLE_BASE_ADDR, srcs[i]), 32'hffff_ffff);
    read_check("register_readback", reg_addr(INTENABLE_BASE_ADDR, srcs[i]), 32'h1);
    bus_write(reg_addr(EXT_INTR_GW_CONFIG, srcs[i]), 32'hffff_fffe);
    read_check("register_readback", reg_addr(EXT_INTR_GW_CONFIG, srcs[i]), 32'h2);
    bus_write(reg_addr(INTENABLE_BASE_ADDR, srcs[i]), 32'hffff_fffe);
    read_check("register_readback", reg_addr(INTENABLE_BASE_ADDR, srcs[i]), 32'h0);
    bus_write(reg_addr(EXT_INTR_GW_CONFIG, srcs[i]), 32'h0);
    read_check("register_readback", reg_addr(EXT_INTR_GW_CONFIG, srcs[i]), 32'h0);
  end
  bus_write(reg_addr(INTPRIORITY_BASE_ADDR, 0), 32'hf);  // Reserved slot.
  read_check("register_readback", reg_addr(INTPRIORITY_BASE_ADDR, 0), 32'h0);
  bus_write(reg_addr(INTENABLE_BASE_ADDR, 0), 32'h1);
  read_check("register_readback", reg_addr(INTENABLE_BASE_ADDR, 0), 32'h0);
  bus_write(EXT_INTR_PIC_CONFIG, 32'hffff_ffff);
  read_check("register_readback", EXT_INTR_PIC_CONFIG, 32'h1);
  bus_write(EXT_INTR_PIC_CONFIG, 32'h0);
  read_check("register_readback", EXT_INTR_PIC_CONFIG, 32'h0);
  picm_wren    = 1'b1;  // Read and write of one address in the same cycle.
  picm_rden    = 1'b1;
  picm_wraddr  = reg_addr(INTPRIORITY_BASE_ADDR, 3);
  picm_rdaddr  = reg_addr(INTPRIORITY_BASE_ADDR, 3);
  picm_wr_data = 32'hb;
  @(negedge clk);
  data      = picm_rd_data;
  picm_wren = 1'b0;
  picm_rden = 1'b0;
  check_value("register_readback", "bypass read", 32'hb, data);
  read_check("register_readback", reg_addr(INTPRIORITY_BASE_ADDR, 3), 32'hb);
  read_check("register_readback", PIC_BASE_ADDR + 32'h6000, 32'h0);
endtask

task automatic level_threshold();
  set_source(5, 9, 1);
  meipt            = 4'd3;
  meicurpl         = 4'd3;
  extintsrc_req[5] = 1'b1;
  wait_latency();
  check_claim("level_threshold", 5, 9, 1'b1);
  read_check("level_threshold", INTPEND_BASE_ADDR, 32'h20);
  read_check("level_threshold", INTPEND_BASE_ADDR + 32'h4, 32'h0);
  meipt = 4'd9;
  wait_latency();
  check_claim("level_threshold", 5, 9, 1'b0);
  meipt    = 4'd3;
  meicurpl = 4'd12;
  wait_latency();
  check_claim("level_threshold", 5, 9, 1'b0);
  meicurpl = 4'd3;
  wait_latency();
  check_claim("level_threshold", 5, 9, 1'b1);
  extintsrc_req[5] = 1'b0;
  wait_latency();
  check_claim("level_threshold", 0, 0, 1'b0);
  read_check("level_threshold", INTPEND_BASE_ADDR, 32'h0);
  set_source(5, 0, 0);
  meipt    = 4'd0;
  meicurpl = 4'd0;
endtask

task automatic arbitration();
  int          srcs[8] = '{2, 4, 9, 13, 17, 22, 26, 30};
  int          prios[8];
  bit          enabled[8];
  logic [31:0] draw;
  int          best_idx;
  int          best_p;
  for (int round = 0; round < 2; round++) begin
    foreach (srcs[i]) begin
      draw_bits(4, draw);
      prios[i]   = int'(draw[3:0]);
      enabled[i] = 1'b1;
      set_source(srcs[i], prios[i], 1);
      extintsrc_req[srcs[i]] = 1'b1;
    end
    set_source(20, 15, 0);  // Top priority but disabled.
    extintsrc_req[20] = 1'b1;
    for (int knock = 0; knock < 4; knock++) begin
      wait_latency();
      best_idx = -1;
      best_p   = 0;
      foreach (srcs[i]) begin
        if (enabled[i] && prios[i] > best_p) begin  // Ascending ids keep the lowest on ties.
          best_idx = i;
          best_p   = prios[i];
        end
      end
      check_claim("arbitration", (best_idx < 0) ? 0 : srcs[best_idx], best_p, best_p > 0);
      if (best_idx >= 0) begin
        enabled[best_idx] = 1'b0;
        bus_write(reg_addr(INTENABLE_BASE_ADDR, srcs[best_idx]), 32'h0);
      end
    end
    extintsrc_req = '0;
    foreach (srcs[i]) begin
      bus_write(reg_addr(INTENABLE_BASE_ADDR, srcs[i]), 32'h0);
    end
  end
endtask

task automatic edge_gateway();
  set_source(12, 6, 1);
  bus_write(reg_addr(EXT_INTR_GW_CONFIG, 12), 32'h2);
  extintsrc_req[12] = 1'b1;
  @(negedge clk);
  extintsrc_req[12] = 1'b0;  // Single-cycle pulse.
  wait_latency();
  check_claim("edge_gateway", 12, 6, 1'b1);
  repeat (5) @(negedge clk);
  check_claim("edge_gateway", 12, 6, 1'b1);
  bus_write(reg_addr(EXT_INTR_GW_CLEAR, 12), 32'h1);
  wait_latency();
  check_claim("edge_gateway", 0, 0, 1'b0);
  bus_write(reg_addr(EXT_INTR_GW_CONFIG, 12), 32'h0);
  set_source(12, 0, 0);
endtask

task automatic polarity();
  set_source(20, 7, 1);
  bus_write(reg_addr(EXT_INTR_GW_CONFIG, 20), 32'h1);  // Active low, input is low.
  wait_latency();
  check_claim("polarity", 20, 7, 1'b1);
  extintsrc_req[20] = 1'b1;
  wait_latency();
  check_claim("polarity", 0, 0, 1'b0);
  set_source(20, 0, 0);
  bus_write(reg_addr(EXT_INTR_GW_CONFIG, 20), 32'h0);
  extintsrc_req[20] = 1'b0;
endtask

task automatic reverse_order();
  bus_write(EXT_INTR_PIC_CONFIG, 32'h1);
  set_source(3, 4, 1);
  set_source(8, 0, 1);
  extintsrc_req[3] = 1'b1;
  extintsrc_req[8] = 1'b1;
  wait_latency();
  check_claim("reverse_order", 8, 0, 1'b0);  // Threshold 0 is the top level here.
  check_value("reverse_order", "mhwakeup", 32'd1, 32'(mhwakeup));
  meipt    = 4'd15;
  meicurpl = 4'd15;
  wait_latency();
  check_claim("reverse_order", 8, 0, 1'b1);
  extintsrc_req[8] = 1'b0;
  wait_latency();
  check_claim("reverse_order", 3, 4, 1'b1);
  check_value("reverse_order", "mhwakeup", 32'd0, 32'(mhwakeup));
  bus_write(EXT_INTR_PIC_CONFIG, 32'h0);
  meipt    = 4'd0;
  meicurpl = 4'd0;
  bus_write(reg_addr(INTPRIORITY_BASE_ADDR, 3), 32'd15);
  wait_latency();
  check_claim("standard_wakeup", 3, 15, 1'b1);
  check_value("standard_wakeup", "mhwakeup", 32'd1, 32'(mhwakeup));
  bus_write(reg_addr(INTPRIORITY_BASE_ADDR, 3), 32'd14);
  wait_latency();
  check_claim("standard_wakeup", 3, 14, 1'b1);
  check_value("standard_wakeup", "mhwakeup", 32'd0, 32'(mhwakeup));
  extintsrc_req[3] = 1'b0;
  set_source(3, 0, 0);
  set_source(8, 0, 0);
endtask

/* tests/tb_pic_ctrl.sv */
module tb_pic_ctrl
  import pic_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TEST_CYCLES    = 600;                   // Upper bound for the whole sequence.
  localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES + 200;

  logic        clk;
  logic        rst;
  src_vec_t    extintsrc_req;
  logic        picm_rden;
  logic        picm_wren;
  logic [31:0] picm_rdaddr;
  logic [31:0] picm_wraddr;
  logic [31:0] picm_wr_data;
  prio_t       meipt;
  prio_t       meicurpl;
  logic [31:0] picm_rd_data;
  int_id_t     claimid;
  prio_t       pl;
  logic        mexintpend;
  logic        mhwakeup;
  logic [31:0] lfsr_state;
  int          cycle_count = 0;

  pic_ctrl dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("The tests did not finish within %0d clock cycles.", TIMEOUT_CYCLES));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reporting and stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string test_name, string what, logic [31:0] expected,
                             logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("ERROR %s: %s expected 0x%0h actual 0x%0h",
                         test_name, what, expected, actual));
    end
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_bits(int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};  // One step per bit.
    end
  endtask

  function automatic logic [31:0] reg_addr(logic [31:0] base, int src);
    return base + 32'(4 * src);
  endfunction

  // All bus tasks start and end on a falling edge.
  task automatic bus_write(logic [31:0] addr, logic [31:0] data);
    @(negedge clk);
    picm_wren    = 1'b1;
    picm_wraddr  = addr;
    picm_wr_data = data;
    @(negedge clk);
    picm_wren = 1'b0;
  endtask

  task automatic bus_read(logic [31:0] addr, output logic [31:0] data);
    @(negedge clk);
    picm_rden   = 1'b1;
    picm_rdaddr = addr;
    @(negedge clk);
    data      = picm_rd_data;  // Valid for the cycle after the capture edge.
    picm_rden = 1'b0;
  endtask

  task automatic read_check(string test_name, logic [31:0] addr, logic [31:0] expected);
    logic [31:0] data;
    bus_read(addr, data);
    check_value(test_name, $sformatf("read 0x%0h", addr), expected, data);
  endtask

  task automatic set_source(int src, int prio, int en);
    bus_write(reg_addr(INTPRIORITY_BASE_ADDR, src), 32'(prio));
    bus_write(reg_addr(INTENABLE_BASE_ADDR, src), 32'(en));
  endtask

  // Inputs taken at the next rising edge reach the outputs two edges later.
  task automatic wait_latency();
    repeat (3) @(negedge clk);
  endtask

  task automatic check_claim(string test_name, int id, int prio, logic pend);
    check_value(test_name, "claimid", 32'(id), 32'(claimid));
    check_value(test_name, "pl", 32'(prio), 32'(pl));
    check_value(test_name, "mexintpend", 32'(pend), 32'(mexintpend));
  endtask

  `include "pic_tests.svh"

  initial begin
    rst           = 1'b1;
    extintsrc_req = '0;
    picm_rden     = 1'b0;
    picm_wren     = 1'b0;
    picm_rdaddr   = '0;
    picm_wraddr   = '0;
    picm_wr_data  = '0;
    meipt         = '0;
    meicurpl      = '0;
    lfsr_state    = 32'h5792_d6d4;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    check_claim("reset", 0, 0, 1'b0);
    check_value("reset", "mhwakeup", 32'd0, 32'(mhwakeup));
    register_readback();
    level_threshold();
    arbitration();
    edge_gateway();
    polarity();
    reverse_order();
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* rtl/pic_ctrl.sv */
module pic_ctrl
  import pic_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  src_vec_t    extintsrc_req,
  input  logic        picm_rden,
  input  logic        picm_wren,
  input  logic [31:0] picm_rdaddr,
  input  logic [31:0] picm_wraddr,
  input  logic [31:0] picm_wr_data,
  input  prio_t       meipt,
  input  prio_t       meicurpl,
  output logic [31:0] picm_rd_data,
  output int_id_t     claimid,
  output prio_t       pl,
  output logic        mexintpend,
  output logic        mhwakeup
);

  pic_bus_req_t bus_req;
  pic_cfg_t     cfg;
  src_vec_t     gw_clear;
  src_vec_t     gw_pending;
  pic_winner_t  winner;

  assign bus_req = '{rden: picm_rden, wren: picm_wren, rdaddr: picm_rdaddr,
                     wraddr: picm_wraddr, wr_data: picm_wr_data};

  pic_gateway_bank gw_bank0 (
    .clk           (clk),
    .rst           (rst),
    .extintsrc_req (extintsrc_req),
    .cfg           (cfg),
    .gw_clear      (gw_clear),
    .gw_pending    (gw_pending)
  );

  pic_regfile regs0 (
    .clk        (clk),
    .rst        (rst),
    .bus_req    (bus_req),
    .gw_pending (gw_pending),
    .cfg        (cfg),
    .gw_clear   (gw_clear),
    .rd_data    (picm_rd_data)
  );

  pic_priority_tree tree0 (
    .gw_pending (gw_pending),
    .cfg        (cfg),
    .winner     (winner)
  );

  pic_claim_stage claim0 (
    .clk        (clk),
    .rst        (rst),
    .winner     (winner),
    .priord     (cfg.priord),
    .meipt      (meipt),
    .meicurpl   (meicurpl),
    .claimid    (claimid),
    .pl         (pl),
    .mexintpend (mexintpend),
    .mhwakeup   (mhwakeup)
  );

endmodule

/* rtl/pic_claim_stage.sv */
module pic_claim_stage
  import pic_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  pic_winner_t winner,
  input  logic        priord,
  input  prio_t       meipt,
  input  prio_t       meicurpl,
  output int_id_t     claimid,
  output prio_t       pl,
  output logic        mexintpend,
  output logic        mhwakeup
);

  prio_t pl_next;
  prio_t meipt_eff;
  prio_t meicurpl_eff;
  prio_t max_pl;

  assign pl_next      = priord ? ~winner.prio : winner.prio;  // Back to programmed order.
  assign meipt_eff    = priord ? ~meipt : meipt;
  assign meicurpl_eff = priord ? ~meicurpl : meicurpl;
  assign max_pl       = priord ? '0 : MAX_PRIORITY;

  always_ff @(posedge clk) begin
    if (rst) begin
      claimid    <= '0;
      pl         <= '0;
      mexintpend <= 1'b0;
      mhwakeup   <= 1'b0;
    end else begin
      claimid    <= winner.id;
      pl         <= pl_next;
      mexintpend <= (winner.prio > meipt_eff) && (winner.prio > meicurpl_eff);
      mhwakeup   <= (pl_next == max_pl);
    end
  end

  a_pend_has_id: assert property (@(posedge clk) disable iff (rst)
    mexintpend |-> (claimid != '0))
    else $error("interrupt pending with no source claimed");

endmodule

/* rtl/pic_priority_tree.sv */
module pic_priority_tree
  import pic_pkg::*;
(
  input  src_vec_t    gw_pending,
  input  pic_cfg_t    cfg,
  output pic_winner_t winner
);

  // Keeps the higher priority; a is the lower-id side, so it wins ties.
  function automatic pic_winner_t cmp_sel(input pic_winner_t a, input pic_winner_t b);
    if (a.prio < b.prio) begin
      return b;
    end
    return a;
  endfunction

  prio_t       eff_prio [NUM_INTS];
  pic_winner_t node     [2*NUM_INTS-1];  // Heap order, node 0 is the root.

  genvar i;
  genvar k;

  for (i = 0; i < NUM_INTS; i++) begin : g_leaf
    always_comb begin
      eff_prio[i] = '0;
      if (gw_pending[i] && cfg.enable[i]) begin
        eff_prio[i] = cfg.priord ? ~cfg.prio[i] : cfg.prio[i];  // Larger is better here.
      end
    end

    assign node[NUM_INTS-1+i] = '{id: int_id_t'(i), prio: eff_prio[i]};
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare-and-select levels
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // NUM_LEVELS rows of pairwise selection; left children hold the lower ids.
  for (k = 0; k < NUM_INTS - 1; k++) begin : g_node
    assign node[k] = cmp_sel(node[2*k+1], node[2*k+2]);
  end

  assign winner = node[0];

endmodule

/* rtl/pic_regfile.sv */
module pic_regfile
  import pic_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  pic_bus_req_t bus_req,
  input  src_vec_t     gw_pending,
  output pic_cfg_t     cfg,
  output src_vec_t     gw_clear,
  output logic [31:0]  rd_data
);

  pic_bus_req_t                 req_q;
  logic [NUM_LEVELS-1:0]        rd_idx;
  logic [NUM_LEVELS-1:0]        wr_idx;
  logic                         rd_prio, rd_enable, rd_gwcfg, rd_piccfg, rd_pend;
  logic                         wr_prio, wr_enable, wr_gwcfg, wr_piccfg, wr_clear;
  logic                         wr_src_ok;
  logic                         bypass;
  logic [INT_GRPS-1:0][31:0]    pend_words;
  logic [31:0]                  sel_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= '0;
    end else begin
      req_q <= bus_req;  // Everything below works on the captured request.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rd_idx = req_q.rdaddr[NUM_LEVELS+1:2];
  assign wr_idx = req_q.wraddr[NUM_LEVELS+1:2];

  assign rd_prio   = req_q.rden &&
                     (req_q.rdaddr[31:NUM_LEVELS+2] == INTPRIORITY_BASE_ADDR[31:NUM_LEVELS+2]);
  assign rd_enable = req_q.rden &&
                     (req_q.rdaddr[31:NUM_LEVELS+2] == INTENABLE_BASE_ADDR[31:NUM_LEVELS+2]);
  assign rd_gwcfg  = req_q.rden &&
                     (req_q.rdaddr[31:NUM_LEVELS+2] == EXT_INTR_GW_CONFIG[31:NUM_LEVELS+2]);
  assign rd_piccfg = req_q.rden && (req_q.rdaddr == EXT_INTR_PIC_CONFIG);
  assign rd_pend   = req_q.rden && (req_q.rdaddr[31:6] == INTPEND_BASE_ADDR[31:6]);

  assign wr_prio   = req_q.wren &&
                     (req_q.wraddr[31:NUM_LEVELS+2] == INTPRIORITY_BASE_ADDR[31:NUM_LEVELS+2]);
  assign wr_enable = req_q.wren &&
                     (req_q.wraddr[31:NUM_LEVELS+2] == INTENABLE_BASE_ADDR[31:NUM_LEVELS+2]);
  assign wr_gwcfg  = req_q.wren &&
                     (req_q.wraddr[31:NUM_LEVELS+2] == EXT_INTR_GW_CONFIG[31:NUM_LEVELS+2]);
  assign wr_clear  = req_q.wren &&
                     (req_q.wraddr[31:NUM_LEVELS+2] == EXT_INTR_GW_CLEAR[31:NUM_LEVELS+2]);
  assign wr_piccfg = req_q.wren && (req_q.wraddr == EXT_INTR_PIC_CONFIG);

  assign wr_src_ok = (wr_idx != '0);  // Writes to source 0 are dropped.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Configuration registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= '0;
    end else begin
      if (wr_prio && wr_src_ok) begin
        cfg.prio[wr_idx] <= req_q.wr_data[3:0];
      end
      if (wr_enable && wr_src_ok) begin
        cfg.enable[wr_idx] <= req_q.wr_data[0];
      end
      if (wr_gwcfg && wr_src_ok) begin
        cfg.gw_polarity[wr_idx] <= req_q.wr_data[0];
        cfg.gw_type[wr_idx]     <= req_q.wr_data[1];
      end
      if (wr_piccfg) begin
        cfg.priord <= req_q.wr_data[0];
      end
    end
  end

  always_comb begin
    gw_clear = '0;
    if (wr_clear && wr_src_ok) begin
      gw_clear[wr_idx] = 1'b1;  // One-cycle pulse into the gateway.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read data
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign pend_words = {{(INT_GRPS * 32 - NUM_INTS){1'b0}}, gw_pending};

  always_comb begin
    sel_data = '0;
    if (rd_prio) begin
      sel_data = {28'b0, cfg.prio[rd_idx]};
    end else if (rd_enable) begin
      sel_data = {31'b0, cfg.enable[rd_idx]};
    end else if (rd_gwcfg) begin
      sel_data = {30'b0, cfg.gw_type[rd_idx], cfg.gw_polarity[rd_idx]};
    end else if (rd_piccfg) begin
      sel_data = {31'b0, cfg.priord};
    end else if (rd_pend) begin
      for (int g = 0; g < INT_GRPS; g++) begin
        if (req_q.rdaddr[5:2] == 4'(g)) begin
          sel_data = pend_words[g];
        end
      end
    end
  end

  // same-cycle write to the read address wins
  assign bypass  = req_q.rden && req_q.wren && (req_q.rdaddr == req_q.wraddr);
  assign rd_data = bypass ? req_q.wr_data : sel_data;

  a_rd_idle_zero: assert property (@(posedge clk) disable iff (rst)
    !req_q.rden |-> (rd_data == '0))
    else $error("read data driven without a captured read");

endmodule

/* rtl/pic_gateway_bank.sv */
module pic_gateway_bank
  import pic_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  src_vec_t extintsrc_req,
  input  pic_cfg_t cfg,
  input  src_vec_t gw_clear,
  output src_vec_t gw_pending
);

  src_vec_t sync_ff1;
  src_vec_t sync_ff2;
  src_vec_t active_next;  // Polarity-corrected level entering the second flop.
  src_vec_t active;
  src_vec_t edge_pend;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Two-flop synchronizer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_ff1 <= '0;
      sync_ff2 <= '0;
    end else begin
      sync_ff1 <= {extintsrc_req[NUM_INTS-1:1], 1'b0};  // Slot 0 is reserved.
      sync_ff2 <= sync_ff1;
    end
  end

  assign active_next = sync_ff1 ^ cfg.gw_polarity;
  assign active      = sync_ff2 ^ cfg.gw_polarity;

  // Sticky pending for edge sources.
  // It loads from the same value the second flop takes, so both rise together.
  always_ff @(posedge clk) begin
    if (rst) begin
      edge_pend <= '0;
    end else begin
      edge_pend <= active_next | (edge_pend & ~gw_clear);
    end
  end

  assign gw_pending = active | (edge_pend & cfg.gw_type);

  a_slot0_idle: assert property (@(posedge clk) disable iff (rst) !gw_pending[0])
    else $error("reserved source 0 reported pending");

endmodule

/* rtl/pic_pkg.sv */
package pic_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int NUM_INTS   = 32;  // Slot 0 is reserved and never pending.
  localparam int NUM_LEVELS = 5;   // Tree depth, also the source index width.
  localparam int INT_GRPS   = (2 ** $clog2(NUM_INTS + 1)) / 32;  // Pending-read words.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [31:0] PIC_BASE_ADDR         = 32'hf00c_0000;
  localparam logic [31:0] INTPRIORITY_BASE_ADDR = PIC_BASE_ADDR;
  localparam logic [31:0] INTPEND_BASE_ADDR     = PIC_BASE_ADDR + 32'h0000_1000;
  localparam logic [31:0] INTENABLE_BASE_ADDR   = PIC_BASE_ADDR + 32'h0000_2000;
  localparam logic [31:0] EXT_INTR_PIC_CONFIG   = PIC_BASE_ADDR + 32'h0000_3000;
  localparam logic [31:0] EXT_INTR_GW_CONFIG    = PIC_BASE_ADDR + 32'h0000_4000;
  localparam logic [31:0] EXT_INTR_GW_CLEAR     = PIC_BASE_ADDR + 32'h0000_5000;

  localparam logic [3:0] MAX_PRIORITY = 4'd15;  // Highest level in standard order.

  typedef logic [3:0]          prio_t;
  typedef logic [7:0]          int_id_t;
  typedef logic [NUM_INTS-1:0] src_vec_t;

  // One bus cycle as seen on the request strobes.
  typedef struct packed {
    logic        rden;
    logic        wren;
    logic [31:0] rdaddr;
    logic [31:0] wraddr;
    logic [31:0] wr_data;
  } pic_bus_req_t;

  // Programmed state, as held by the register file.
  typedef struct packed {
    prio_t [NUM_INTS-1:0] prio;
    src_vec_t             enable;
    src_vec_t             gw_polarity;  // Set means active low.
    src_vec_t             gw_type;      // Set means edge triggered.
    logic                 priord;       // Set selects reverse priority order.
  } pic_cfg_t;

  typedef struct packed {
    int_id_t id;
    prio_t   prio;  // In effective order, so larger always wins.
  } pic_winner_t;

endpackage
